//--- all.f
src/exu_pkg.sv
src/exu_alu.sv
src/exu_lsu.sv
src/exu_stage.sv
src/exu_data_mem.sv
src/exu_top.sv
dv/exu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module exu_tb \
  -f all.f \
  -o exu_sim

./obj_dir/exu_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi

grep -q "Test passed" sim.log

//--- dv/exu_tb.sv
`timescale 1ns/100ps

module exu_tb;

  import exu_pkg::*;

  logic                  clock;
  logic                  reset;
  logic                  flush;
  logic                  in_valid;
  logic                  in_ready;
  logic [XLEN-1:0]       in_pc;
  logic [XLEN-1:0]       in_val_a;
  logic [XLEN-1:0]       in_val_b;
  logic [XLEN-1:0]       in_val_c;
  alu_funct_t            in_alu_funct;
  logic                  in_alu_sw;
  logic [REG_ADDR_W-1:0] in_rd;
  logic                  in_rd_src;
  ls_op_t                in_ls;
  logic                  out_valid;
  logic                  out_ready;
  logic [XLEN-1:0]       out_pc;
  logic [REG_ADDR_W-1:0] out_gpr_waddr;
  logic [XLEN-1:0]       out_gpr_wdata;
  logic [REG_ADDR_W-1:0] exu_rd;

  logic [31:0]           lfsr;
  // byte image of the first 16 memory words
  logic [7:0]            shadow [64];
  int                    errors;
  int                    tests;
  int                    xfers;
  int                    lat;
  logic [XLEN-1:0]       got_pc;
  logic [XLEN-1:0]       got_data;
  logic [REG_ADDR_W-1:0] got_rd;

  exu_top #(
    .MEM_WORDS (256),
    .MEM_DELAY (3)
  ) dut_i (
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_pc         (in_pc),
    .in_val_a      (in_val_a),
    .in_val_b      (in_val_b),
    .in_val_c      (in_val_c),
    .in_alu_funct  (in_alu_funct),
    .in_alu_sw     (in_alu_sw),
    .in_rd         (in_rd),
    .in_rd_src     (in_rd_src),
    .in_ls         (in_ls),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_gpr_waddr (out_gpr_waddr),
    .out_gpr_wdata (out_gpr_wdata),
    .exu_rd        (exu_rd)
  );

  always #20 clock = ~clock;

  // write-back transfers, sampled mid-cycle where everything is settled
  always @(negedge clock) begin
    if (!reset && out_valid && out_ready) begin
      xfers = xfers + 1;
      got_pc = out_pc;
      got_data = out_gpr_wdata;
      got_rd = out_gpr_waddr;
    end
  end

  // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [31:0] rand_bits(int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // rv32i register-register result
  function automatic logic [31:0] alu_ref(int f, logic alt, logic [31:0] a, logic [31:0] b);
    logic [4:0] s;
    s = b[4:0];
    case (f)
      0: return alt ? a - b : a + b;
      1: return a << s;
      2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: return (a < b) ? 32'd1 : 32'd0;
      4: return a ^ b;
      5: return alt ? 32'($signed(a) >>> s) : a >> s;
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // expected load value from the byte image, little endian
  function automatic logic [31:0] load_ref(ls_op_t op, int addr);
    logic [7:0]  b0;
    logic [15:0] h;
    b0 = shadow[addr];
    h = {shadow[addr | 1], shadow[addr]};
    case (op)
      LS_LB: return {{24{b0[7]}}, b0};
      LS_LBU: return {24'd0, b0};
      LS_LH: return {{16{h[15]}}, h};
      LS_LHU: return {16'd0, h};
      default: return {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    endcase
  endfunction

  task automatic mismatch(string sig, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("ERROR at %0t: %s is %h, expected %h", $time, sig, got, exp);
  endtask

  task automatic fail_note(string msg);
    errors++;
    $display("at %0t: %s", $time, msg);
  endtask

  task automatic test_done(string name, int e0);
    tests++;
    $display("%s: %0d errors", name, errors - e0);
  endtask

  // offer one instruction, returns just after the accepting edge
  task automatic send(ls_op_t op, logic [31:0] a, logic [31:0] b, logic [31:0] c,
                      int f, logic alt, logic [4:0] rd, logic rd_src);
    int n;
    n = 0;
    in_valid = 1'b1;
    in_pc = rand_bits(32);
    in_val_a = a;
    in_val_b = b;
    in_val_c = c;
    in_alu_funct = alu_funct_t'(f[2:0]);
    in_alu_sw = alt;
    in_rd = rd;
    in_rd_src = rd_src;
    in_ls = op;
    do begin
      @(negedge clock);
      n++;
    end while (!in_ready && n < 50);
    if (!in_ready) begin
      fail_note("timed out waiting for in_ready");
    end
    @(posedge clock);
    #5;
    in_valid = 1'b0;
  endtask

  // next write-back transfer, lat counts cycles from acceptance
  task automatic wait_out();
    int start;
    start = xfers;
    lat = 0;
    while (xfers == start && lat < 50) begin
      @(posedge clock);
      #5;
      lat++;
    end
    if (xfers == start) begin
      fail_note("timed out waiting for a write-back transfer");
    end
  endtask

  task automatic execute(ls_op_t op, logic [31:0] a, logic [31:0] b, logic [31:0] c,
                         int f, logic alt, logic [4:0] rd, logic rd_src);
    send(op, a, b, c, f, alt, rd, rd_src);
    wait_out();
  endtask

  // address split over both operands so the lsu adder is used
  task automatic store(ls_op_t op, int addr, logic [31:0] d);
    logic [31:0] off;
    int          size;
    off = rand_bits(32);
    size = (op == LS_SB) ? 1 : ((op == LS_SH) ? 2 : 4);
    for (int i = 0; i < size; i++) begin
      shadow[addr + i] = d[8*i +: 8];
    end
    execute(op, 32'(addr) - off, off, d, 0, 1'b0, 5'd0, 1'b0);
  endtask

  task automatic test_alu();
    int          e0;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [4:0]  rd;
    e0 = errors;
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        a = rand_bits(32);
        b = rand_bits(32);
        rd = 5'(rand_bits(5));
        execute(LS_NONE, a, b, 32'd0, f, alt[0], rd, 1'b0);
        exp = alu_ref(f, alt[0], a, b);
        if (lat != 1) begin
          fail_note($sformatf("alu result came %0d cycles after acceptance", lat));
        end
        if (got_data !== exp) begin
          mismatch("out_gpr_wdata", got_data, exp);
        end
        if (got_rd !== rd) begin
          mismatch("out_gpr_waddr", 32'(got_rd), 32'(rd));
        end
        if (got_pc !== in_pc) begin
          mismatch("out_pc", got_pc, in_pc);
        end
      end
    end
    test_done("alu ops", e0);
  endtask

  task automatic test_mem();
    int          e0;
    int          addr;
    int          kind;
    ls_op_t      op;
    ls_op_t      loads [5];
    logic [31:0] off;
    logic [31:0] exp;
    logic [4:0]  rd;
    e0 = errors;
    loads = '{LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};
    // known words first, the memory itself has no reset
    for (int w = 0; w < 16; w++) begin
      store(LS_SW, w * 4, rand_bits(32));
    end
    for (int i = 0; i < 24; i++) begin
      kind = int'(rand_bits(2)) % 3;
      addr = int'(rand_bits(6)) & ~((1 << kind) - 1);
      store(kind == 0 ? LS_SB : (kind == 1 ? LS_SH : LS_SW), addr, rand_bits(32));
    end
    for (int i = 0; i < 30; i++) begin
      op = loads[int'(rand_bits(3)) % 5];
      addr = int'(rand_bits(6)) & ~((1 << op[1:0]) - 1);
      off = rand_bits(32);
      rd = 5'(rand_bits(5));
      execute(op, 32'(addr) - off, off, 32'd0, 0, 1'b0, rd, 1'b0);
      exp = load_ref(op, addr);
      if (got_data !== exp) begin
        mismatch($sformatf("out_gpr_wdata (%s @%0d)", op.name(), addr), got_data, exp);
      end
      if (got_rd !== rd) begin
        mismatch("out_gpr_waddr", 32'(got_rd), 32'(rd));
      end
    end
    test_done("stores and loads", e0);
  endtask

  // hold out_ready low and watch the offer stay put
  task automatic stall_check(ls_op_t op, logic [31:0] a, logic [31:0] b, int f,
                             logic [31:0] exp);
    int          start;
    int          n;
    logic [31:0] pc_h;
    logic [31:0] data_h;
    logic [4:0]  rd_h;
    start = xfers;
    n = 0;
    out_ready = 1'b0;
    send(op, a, b, 32'd0, f, 1'b0, 5'(rand_bits(5)), 1'b0);
    do begin
      @(negedge clock);
      n++;
    end while (!out_valid && n < 50);
    if (!out_valid) begin
      fail_note("timed out waiting for out_valid under back-pressure");
    end
    pc_h = out_pc;
    data_h = out_gpr_wdata;
    rd_h = out_gpr_waddr;
    if (data_h !== exp) begin
      mismatch("out_gpr_wdata", data_h, exp);
    end
    repeat (5) begin
      @(negedge clock);
      if (!out_valid || out_pc !== pc_h || out_gpr_wdata !== data_h ||
          out_gpr_waddr !== rd_h) begin
        fail_note("write-back offer changed while out_ready was low");
      end
      if (in_ready) begin
        fail_note("in_ready high while the stage was stalled");
      end
    end
    @(posedge clock);
    #5;
    out_ready = 1'b1;
    // window long enough to catch a duplicate transfer
    repeat (4) begin
      @(posedge clock);
      #5;
    end
    if (xfers != start + 1) begin
      fail_note($sformatf("%0d transfers after back-pressure, expected 1", xfers - start));
    end
  endtask

  task automatic test_stall();
    int          e0;
    logic [31:0] a;
    logic [31:0] b;
    e0 = errors;
    a = rand_bits(32);
    b = rand_bits(32);
    stall_check(LS_NONE, a, b, 6, a | b);
    stall_check(LS_LW, 32'd20, 32'd0, 0, load_ref(LS_LW, 20));
    test_done("back-pressure", e0);
  endtask

  task automatic flush_now();
    flush = 1'b1;
    @(posedge clock);
    #5;
    flush = 1'b0;
  endtask

  task automatic test_flush();
    int          e0;
    int          start;
    logic [31:0] a;
    e0 = errors;
    start = xfers;
    a = rand_bits(32);
    // alu op held by back-pressure, then dropped
    out_ready = 1'b0;
    send(LS_NONE, a, a, 32'd0, 0, 1'b0, 5'd7, 1'b0);
    flush_now();
    out_ready = 1'b1;
    // load dropped while its request is still on the bus
    send(LS_LW, 32'd8, 32'd0, 32'd0, 0, 1'b0, 5'd9, 1'b0);
    flush_now();
    repeat (8) begin
      @(posedge clock);
      #5;
    end
    if (xfers != start) begin
      fail_note("a flushed instruction reached write-back");
    end
    if (exu_rd !== 5'd0) begin
      mismatch("exu_rd", 32'(exu_rd), 32'd0);
    end
    execute(LS_LW, 32'd8, 32'd0, 32'd0, 0, 1'b0, 5'd11, 1'b0);
    if (got_data !== load_ref(LS_LW, 8)) begin
      mismatch("out_gpr_wdata after flush", got_data, load_ref(LS_LW, 8));
    end
    if (got_rd !== 5'd11) begin
      mismatch("out_gpr_waddr after flush", 32'(got_rd), 32'd11);
    end
    test_done("flush", e0);
  endtask

  task automatic test_pass();
    int          e0;
    logic [31:0] a;
    e0 = errors;
    a = rand_bits(32);
    execute(LS_NONE, a, rand_bits(32), 32'd0, 4, 1'b0, 5'd21, 1'b1);
    if (got_data !== a) begin
      mismatch("out_gpr_wdata", got_data, a);
    end
    // pending destination while held, then while a load is in flight
    out_ready = 1'b0;
    send(LS_NONE, a, a, 32'd0, 0, 1'b0, 5'd13, 1'b0);
    @(negedge clock);
    if (exu_rd !== 5'd13) begin
      mismatch("exu_rd", 32'(exu_rd), 32'd13);
    end
    @(posedge clock);
    #5;
    out_ready = 1'b1;
    wait_out();
    send(LS_LBU, 32'd3, 32'd0, 32'd0, 0, 1'b0, 5'd17, 1'b0);
    @(negedge clock);
    if (exu_rd !== 5'd17) begin
      mismatch("exu_rd", 32'(exu_rd), 32'd17);
    end
    wait_out();
    test_done("pass-through and hazard", e0);
  endtask

  initial begin
    lfsr = 32'h1e1eba03;
    errors = 0;
    tests = 0;
    xfers = 0;
    clock = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    in_valid = 1'b0;
    in_pc = '0;
    in_val_a = '0;
    in_val_b = '0;
    in_val_c = '0;
    in_alu_funct = ALU_ADD;
    in_alu_sw = 1'b0;
    in_rd = '0;
    in_rd_src = 1'b0;
    in_ls = LS_NONE;
    out_ready = 1'b1;
    repeat (3) @(posedge clock);
    #5;
    reset = 1'b0;
    @(negedge clock);
    if (!in_ready || out_valid || exu_rd !== 5'd0) begin
      fail_note("stage not empty after reset");
    end
    @(posedge clock);
    #5;
    test_alu();
    test_mem();
    test_stall();
    test_flush();
    test_pass();
    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- src/exu_top.sv
`timescale 1ns/100ps

module exu_top #(
  parameter int MEM_WORDS = 256,
  parameter int MEM_DELAY = 2
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [exu_pkg::XLEN-1:0]       in_pc,
  input  logic [exu_pkg::XLEN-1:0]       in_val_a,
  input  logic [exu_pkg::XLEN-1:0]       in_val_b,
  input  logic [exu_pkg::XLEN-1:0]       in_val_c,
  input  exu_pkg::alu_funct_t            in_alu_funct,
  input  logic                           in_alu_sw,
  input  logic [exu_pkg::REG_ADDR_W-1:0] in_rd,
  input  logic                           in_rd_src,
  input  exu_pkg::ls_op_t                in_ls,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [exu_pkg::XLEN-1:0]       out_pc,
  output logic [exu_pkg::REG_ADDR_W-1:0] out_gpr_waddr,
  output logic [exu_pkg::XLEN-1:0]       out_gpr_wdata,
  output logic [exu_pkg::REG_ADDR_W-1:0] exu_rd
);

  import exu_pkg::*;

  // stage to lsu
  logic                  lsu_start;
  ls_op_t                lsu_ls;
  logic [XLEN-1:0]       lsu_val_a;
  logic [XLEN-1:0]       lsu_val_b;
  logic [XLEN-1:0]       lsu_store_data;
  logic                  lsu_release;
  logic                  lsu_busy;
  logic                  lsu_done;
  logic [XLEN-1:0]       lsu_rdata;
  // lsu to data memory
  logic                  mem_req_valid;
  logic                  mem_req_ready;
  logic                  mem_req_write;
  logic [MEM_ADDR_W-1:0] mem_req_addr;
  logic [XLEN-1:0]       mem_req_wdata;
  logic [MEM_STRB_W-1:0] mem_req_wstrb;
  logic                  mem_resp_valid;
  logic [XLEN-1:0]       mem_resp_rdata;

  exu_stage stage_i (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_pc          (in_pc),
    .in_val_a       (in_val_a),
    .in_val_b       (in_val_b),
    .in_val_c       (in_val_c),
    .in_alu_funct   (in_alu_funct),
    .in_alu_sw      (in_alu_sw),
    .in_rd          (in_rd),
    .in_rd_src      (in_rd_src),
    .in_ls          (in_ls),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_gpr_waddr  (out_gpr_waddr),
    .out_gpr_wdata  (out_gpr_wdata),
    .exu_rd         (exu_rd),
    .lsu_start      (lsu_start),
    .lsu_ls         (lsu_ls),
    .lsu_val_a      (lsu_val_a),
    .lsu_val_b      (lsu_val_b),
    .lsu_store_data (lsu_store_data),
    .lsu_release    (lsu_release),
    .lsu_busy       (lsu_busy),
    .lsu_done       (lsu_done),
    .lsu_rdata      (lsu_rdata)
  );

  exu_lsu lsu_i (
    .clock          (clock),
    .reset          (reset),
    .start          (lsu_start),
    .ls             (lsu_ls),
    .val_a          (lsu_val_a),
    .val_b          (lsu_val_b),
    .store_data     (lsu_store_data),
    .clear          (lsu_release),
    .busy           (lsu_busy),
    .done           (lsu_done),
    .rdata          (lsu_rdata),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_req_wstrb  (mem_req_wstrb),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata)
  );

  exu_data_mem #(
    .MEM_WORDS (MEM_WORDS),
    .MEM_DELAY (MEM_DELAY)
  ) data_mem_i (
    .clock          (clock),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_req_wstrb  (mem_req_wstrb),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata)
  );

endmodule

//--- src/exu_data_mem.sv
`timescale 1ns/100ps

module exu_data_mem #(
  parameter int MEM_WORDS = 256,
  parameter int MEM_DELAY = 2
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           mem_req_valid,
  output logic                           mem_req_ready,
  input  logic                           mem_req_write,
  input  logic [exu_pkg::MEM_ADDR_W-1:0] mem_req_addr,
  input  logic [exu_pkg::XLEN-1:0]       mem_req_wdata,
  input  logic [exu_pkg::MEM_STRB_W-1:0] mem_req_wstrb,
  output logic                           mem_resp_valid,
  output logic [exu_pkg::XLEN-1:0]       mem_resp_rdata
);

  import exu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(MEM_DELAY + 1);

  logic [XLEN-1:0]  mem [MEM_WORDS];
  // upper address bits are dropped, accesses wrap
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             pending;
  logic [CNT_W-1:0] cnt;

  assign idx = mem_req_addr[IDX_W-1:0];
  assign accept = mem_req_valid && mem_req_ready;

  // one access in flight at a time
  assign mem_req_ready = !pending;

  // array and read word, both at the request edge
  always_ff @(posedge clock) begin
    if (accept) begin
      mem_resp_rdata <= mem[idx];
      if (mem_req_write) begin
        for (int b = 0; b < MEM_STRB_W; b++) begin
          if (mem_req_wstrb[b]) begin
            mem[idx][8*b +: 8] <= mem_req_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // pulse in the MEM_DELAY-th cycle after the request edge
  assign mem_resp_valid = pending && (cnt == CNT_W'(MEM_DELAY - 1));

  // delay counter, ready stays low through the response cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
      cnt <= '0;
    end else if (accept) begin
      pending <= 1'b1;
      cnt <= '0;
    end else if (mem_resp_valid) begin
      pending <= 1'b0;
    end else if (pending) begin
      cnt <= cnt + 1'b1;
    end
  end

  // every accepted request is answered after exactly MEM_DELAY cycles
  a_resp_delay: assert property (@(posedge clock) disable iff (reset)
    accept |-> ##MEM_DELAY mem_resp_valid);

endmodule

//--- src/exu_stage.sv
`timescale 1ns/100ps

module exu_stage (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           flush,
  // decode side
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [exu_pkg::XLEN-1:0]       in_pc,
  input  logic [exu_pkg::XLEN-1:0]       in_val_a,
  input  logic [exu_pkg::XLEN-1:0]       in_val_b,
  input  logic [exu_pkg::XLEN-1:0]       in_val_c,
  input  exu_pkg::alu_funct_t            in_alu_funct,
  input  logic                           in_alu_sw,
  input  logic [exu_pkg::REG_ADDR_W-1:0] in_rd,
  input  logic                           in_rd_src,
  input  exu_pkg::ls_op_t                in_ls,
  // write-back side
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [exu_pkg::XLEN-1:0]       out_pc,
  output logic [exu_pkg::REG_ADDR_W-1:0] out_gpr_waddr,
  output logic [exu_pkg::XLEN-1:0]       out_gpr_wdata,
  // pending destination for hazard checks in decode
  output logic [exu_pkg::REG_ADDR_W-1:0] exu_rd,
  // load/store unit
  output logic                           lsu_start,
  output exu_pkg::ls_op_t                lsu_ls,
  output logic [exu_pkg::XLEN-1:0]       lsu_val_a,
  output logic [exu_pkg::XLEN-1:0]       lsu_val_b,
  output logic [exu_pkg::XLEN-1:0]       lsu_store_data,
  output logic                           lsu_release,
  input  logic                           lsu_busy,
  input  logic                           lsu_done,
  input  logic [exu_pkg::XLEN-1:0]       lsu_rdata
);

  import exu_pkg::*;

  logic                  valid;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       val_a;
  logic [XLEN-1:0]       val_b;
  alu_funct_t            alu_funct;
  logic                  alu_sw;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rd_src;
  ls_op_t                ls;
  logic                  accept;
  logic                  retire;
  logic                  exec_done;
  logic [XLEN-1:0]       alu_val;

  // flush in the same cycle blocks the handover
  assign accept = in_valid && in_ready && !flush;
  assign retire = out_valid && out_ready;

  // empty or emptying, and no memory access still on the bus
  assign in_ready = (!valid || retire) && !lsu_busy;

  // alu results are ready at once, memory ops wait for the lsu
  assign exec_done = (ls == LS_NONE) || lsu_done;
  assign out_valid = valid && !flush && exec_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (accept) begin
      valid <= 1'b1;
    end else if (flush || retire) begin
      valid <= 1'b0;
    end
  end

  // instruction register
  always_ff @(posedge clock) begin
    if (accept) begin
      pc <= in_pc;
      val_a <= in_val_a;
      val_b <= in_val_b;
      alu_funct <= in_alu_funct;
      alu_sw <= in_alu_sw;
      rd <= in_rd;
      rd_src <= in_rd_src;
      ls <= in_ls;
    end
  end

  exu_alu alu_i (
    .alu_a (val_a),
    .alu_b (val_b),
    .funct (alu_funct),
    .sw    (alu_sw),
    .val   (alu_val)
  );

  // lsu sees the operands on the way in, it computes its own address
  assign lsu_start = accept && (in_ls != LS_NONE);
  assign lsu_ls = in_ls;
  assign lsu_val_a = in_val_a;
  assign lsu_val_b = in_val_b;
  assign lsu_store_data = in_val_c;
  // frees held load data, or marks an in-flight access as dead
  assign lsu_release = retire || flush;

  // write-back value
  assign out_pc = pc;
  assign out_gpr_waddr = rd;
  assign out_gpr_wdata = ls[3] ? lsu_rdata : (rd_src ? val_a : alu_val);

  assign exu_rd = rd & {REG_ADDR_W{valid}};

  // write-back side may rely on a stalled offer staying put
  a_out_stable: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> flush || (out_valid && $stable(out_pc) &&
      $stable(out_gpr_waddr) && $stable(out_gpr_wdata)));

endmodule

//--- src/exu_lsu.sv
`timescale 1ns/100ps

module exu_lsu (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           start,
  input  exu_pkg::ls_op_t                ls,
  input  logic [exu_pkg::XLEN-1:0]       val_a,
  input  logic [exu_pkg::XLEN-1:0]       val_b,
  input  logic [exu_pkg::XLEN-1:0]       store_data,
  input  logic                           clear,
  output logic                           busy,
  output logic                           done,
  output logic [exu_pkg::XLEN-1:0]       rdata,
  output logic                           mem_req_valid,
  input  logic                           mem_req_ready,
  output logic                           mem_req_write,
  output logic [exu_pkg::MEM_ADDR_W-1:0] mem_req_addr,
  output logic [exu_pkg::XLEN-1:0]       mem_req_wdata,
  output logic [exu_pkg::MEM_STRB_W-1:0] mem_req_wstrb,
  input  logic                           mem_resp_valid,
  input  logic [exu_pkg::XLEN-1:0]       mem_resp_rdata
);

  import exu_pkg::*;

  logic [XLEN-1:0]       addr_in;
  logic [XLEN-1:0]       addr_q;
  ls_op_t                op_q;
  logic [MEM_STRB_W-1:0] strb_in;
  logic [XLEN-1:0]       lane;
  logic [XLEN-1:0]       load_val;
  // response of a flushed access is thrown away
  logic                  drop;

  // own adder on the incoming operands, stage adds nothing across its register
  assign addr_in = val_a + val_b;

  // strobes for the access size, then moved to the byte lane
  always_comb begin
    case (ls[1:0])
      2'd0:    strb_in = MEM_STRB_W'(4'b0001) << addr_in[1:0];
      2'd1:    strb_in = MEM_STRB_W'(4'b0011) << addr_in[1:0];
      default: strb_in = {MEM_STRB_W{1'b1}};
    endcase
  end

  assign mem_req_addr = addr_q[XLEN-1:2];

  // addressed byte or half brought down to bit 0
  assign lane = mem_resp_rdata >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (op_q)
      LS_LB:   load_val = {{(XLEN-8){lane[7]}}, lane[7:0]};
      LS_LH:   load_val = {{(XLEN-16){lane[15]}}, lane[15:0]};
      LS_LBU:  load_val = {{(XLEN-8){1'b0}}, lane[7:0]};
      LS_LHU:  load_val = {{(XLEN-16){1'b0}}, lane[15:0]};
      default: load_val = lane;
    endcase
  end

  // control state
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      drop <= 1'b0;
      mem_req_valid <= 1'b0;
    end else begin
      // request goes up the cycle after start, down once taken
      if (start) begin
        busy <= 1'b1;
        mem_req_valid <= 1'b1;
      end else if (mem_req_valid && mem_req_ready) begin
        mem_req_valid <= 1'b0;
      end
      if (mem_resp_valid && busy) begin
        busy <= 1'b0;
        drop <= 1'b0;
        // flushed item only frees the unit
        done <= !drop && !clear;
      end else if (clear) begin
        done <= 1'b0;
        if (busy) begin
          drop <= 1'b1;
        end
      end
    end
  end

  // payload, captured at start
  always_ff @(posedge clock) begin
    if (start) begin
      op_q <= ls;
      addr_q <= addr_in;
      mem_req_write <= !ls[3];
      mem_req_wdata <= store_data << {addr_in[1:0], 3'b000};
      mem_req_wstrb <= strb_in;
    end
    // load data held here until the stage retires it
    if (mem_resp_valid && busy) begin
      rdata <= load_val;
    end
  end

  // decode must not hand over misaligned half or word accesses
  a_half_aligned: assert property (@(posedge clock) disable iff (reset)
    start && ls[1:0] == 2'd1 |-> !addr_in[0]);
  a_word_aligned: assert property (@(posedge clock) disable iff (reset)
    start && ls[1:0] == 2'd2 |-> addr_in[1:0] == 2'b00);

endmodule

//--- src/exu_alu.sv
`timescale 1ns/100ps

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] alu_a,
  input  logic [exu_pkg::XLEN-1:0] alu_b,
  input  exu_pkg::alu_funct_t      funct,
  input  logic                     sw,
  output logic [exu_pkg::XLEN-1:0] val
);

  import exu_pkg::*;

  // rv32 shifts only look at the low five bits
  logic [4:0] shamt;

  assign shamt = alu_b[4:0];

  always_comb begin
    case (funct)
      ALU_ADD: begin
        // sub when the alternate bit is set
        val = sw ? (alu_a - alu_b) : (alu_a + alu_b);
      end
      ALU_SLL: begin
        val = alu_a << shamt;
      end
      ALU_SLT: begin
        val = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      end
      ALU_SLTU: begin
        val = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      end
      ALU_XOR: begin
        val = alu_a ^ alu_b;
      end
      ALU_SRL: begin
        // arithmetic shift keeps the sign bit
        val = sw ? XLEN'($signed(alu_a) >>> shamt) : (alu_a >> shamt);
      end
      ALU_OR: begin
        val = alu_a | alu_b;
      end
      default: begin
        val = alu_a & alu_b;
      end
    endcase
  end

endmodule

//--- src/exu_pkg.sv
package exu_pkg;

  // datapath and address width
  parameter int XLEN = 32;

  // register file index width
  parameter int REG_ADDR_W = 5;

  // memory bus carries word addresses and one strobe per byte
  parameter int MEM_ADDR_W = XLEN - 2;
  parameter int MEM_STRB_W = XLEN / 8;

  // alu function, same numbering as rv32 funct3
  // alternate bit turns add into sub and srl into sra
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SLL  = 3'd1,
    ALU_SLT  = 3'd2,
    ALU_SLTU = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SRL  = 3'd5,
    ALU_OR   = 3'd6,
    ALU_AND  = 3'd7
  } alu_funct_t;

  // load/store code
  // bit 3 marks a load, bit 2 a store (or unsigned for loads)
  // low two bits are the access size: 0 byte, 1 half, 2 word
  typedef enum logic [3:0] {
    LS_NONE = 4'b0000,
    LS_SB   = 4'b0100,
    LS_SH   = 4'b0101,
    LS_SW   = 4'b0110,
    LS_LB   = 4'b1000,
    LS_LH   = 4'b1001,
    LS_LW   = 4'b1010,
    LS_LBU  = 4'b1100,
    LS_LHU  = 4'b1101
  } ls_op_t;

endpackage
